//--- all.f
design/dma_pkg.sv
design/dma_data_fifo.sv
design/dma_backend.sv
design/dma_reg_frontend.sv
design/dma_core_wrap.sv
dv/dma_mem_model.sv
dv/dma_tb.sv

//--- dv/dma_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dma_tb import dma_pkg::*; ();

  localparam int unsigned CLK_HALF     = 10;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned MEM_WORDS    = 1024;
  localparam int unsigned NUM_TESTS    = 13;
  localparam int unsigned WD_MARGIN    = 2000;
  localparam logic [31:0] SEED         = 32'h462f_82ac;

  typedef enum logic [2:0] {
    T_COPY,
    T_PAIR,
    T_ZERO,
    T_BADRD,
    T_BADWR,
    T_BUSY
  } test_kind_e;

  typedef struct packed {
    test_kind_e                kind;
    logic [DMA_REG_ADDR_W-1:0] reg_off;
    logic [DMA_ADDR_W-1:0]     src;
    logic [DMA_ADDR_W-1:0]     dst;
    logic [DMA_DATA_W-1:0]     nbytes;
    logic [DMA_ID_W-1:0]       exp_id;
    logic                      exp_err;
  } test_row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  slow;
  reg_req_t              reg_req;
  reg_rsp_t              reg_rsp;
  mem_req_t              mem_req;
  mem_rsp_t              mem_rsp;

  test_row_t             tests [NUM_TESTS];
  logic [DMA_DATA_W-1:0] exp_mem [MEM_WORDS];
  // Last values written to the transfer registers
  logic [DMA_DATA_W-1:0] src_reg;
  logic [DMA_DATA_W-1:0] dst_reg;
  logic [DMA_DATA_W-1:0] bytes_reg;
  logic [DMA_ID_W-1:0]   done_id;
  int                    err_count;
  int                    pass_count;
  int                    fail_count;

  dma_core_wrap dma_core_wrap_inst (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .reg_req_i ( reg_req ),
    .reg_rsp_o ( reg_rsp ),
    .mem_req_o ( mem_req ),
    .mem_rsp_i ( mem_rsp )
  );

  dma_mem_model dma_mem_model_inst (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .slow_i    ( slow    ),
    .mem_req_i ( mem_req ),
    .mem_rsp_o ( mem_rsp )
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("** Error: %s expected 0x%0h got 0x%0h", name, exp, got);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    err_count++;
  endtask

  // One bus access that starts and ends on a falling edge
  task automatic access_reg(input logic wr, input logic [DMA_REG_ADDR_W-1:0] addr,
                            input logic [DMA_DATA_W-1:0] wdata,
                            output logic [DMA_DATA_W-1:0] rdata, output logic err);
    int cycles;
    reg_req.valid = 1'b1;
    reg_req.write = wr;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.wstrb = '1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!reg_rsp.ready);
    if (cycles != 1) begin
      report_failure($sformatf("access at offset 0x%0h answered after %0d cycles",
                               addr, cycles));
    end
    rdata = reg_rsp.rdata;
    err   = reg_rsp.error;
    reg_req.valid = 1'b0;
    reg_req.write = 1'b0;
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [DMA_REG_ADDR_W-1:0] addr,
                           input logic [DMA_DATA_W-1:0] data, output logic err);
    logic [DMA_DATA_W-1:0] unused;
    access_reg(1'b1, addr, data, unused, err);
  endtask

  task automatic read_reg(input logic [DMA_REG_ADDR_W-1:0] addr,
                          output logic [DMA_DATA_W-1:0] data, output logic err);
    access_reg(1'b0, addr, '0, data, err);
  endtask

  task automatic expect_reg(input logic [DMA_REG_ADDR_W-1:0] addr,
                            input logic [DMA_DATA_W-1:0] exp, input string name);
    logic [DMA_DATA_W-1:0] rdata;
    logic                  err;
    read_reg(addr, rdata, err);
    if (rdata !== exp) begin
      report_mismatch(name, rdata, exp);
    end
    if (err !== 1'b0) begin
      report_mismatch({name, ".error"}, err, 64'h0);
    end
  endtask

  task automatic program_regs(input test_row_t row);
    logic err;
    src_reg   = {32'h0, row.src};
    dst_reg   = {32'h0, row.dst};
    bytes_reg = row.nbytes;
    write_reg(REG_SRC_ADDR, src_reg, err);
    if (err !== 1'b0) begin
      report_mismatch("src_addr.error", err, 64'h0);
    end
    write_reg(REG_DST_ADDR, dst_reg, err);
    if (err !== 1'b0) begin
      report_mismatch("dst_addr.error", err, 64'h0);
    end
    write_reg(REG_NUM_BYTES, bytes_reg, err);
    if (err !== 1'b0) begin
      report_mismatch("num_bytes.error", err, 64'h0);
    end
    expect_reg(REG_SRC_ADDR, src_reg, "src_addr");
    expect_reg(REG_DST_ADDR, dst_reg, "dst_addr");
    expect_reg(REG_NUM_BYTES, bytes_reg, "num_bytes");
  endtask

  // Next-ID read that also updates the expected memory image
  task automatic launch_transfer(input test_row_t row);
    logic [DMA_DATA_W-1:0] rdata;
    logic                  err;
    logic [DMA_DATA_W-1:0] words;
    read_reg(REG_NEXT_ID, rdata, err);
    if (rdata !== {48'h0, row.exp_id}) begin
      report_mismatch("next_id", rdata, {48'h0, row.exp_id});
    end
    if (err !== row.exp_err) begin
      report_mismatch("next_id.error", err, row.exp_err);
    end
    words = row.nbytes >> 3;
    for (int unsigned i = 0; i < words; i++) begin
      exp_mem[(row.dst >> 3) + i] = exp_mem[(row.src >> 3) + i];
    end
  endtask

  task automatic wait_done(input logic [DMA_ID_W-1:0] id);
    logic [DMA_DATA_W-1:0] rdata;
    logic                  err;
    do begin
      read_reg(REG_DONE_ID, rdata, err);
    end while (rdata[DMA_ID_W-1:0] != id);
    done_id = id;
  endtask

  task automatic compare_memory();
    logic [DMA_DATA_W-1:0] got;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      got = dma_mem_model_inst.read_word(i);
      if (got !== exp_mem[i]) begin
        report_mismatch($sformatf("mem[0x%0h]", i * 8), got, exp_mem[i]);
      end
    end
  endtask

  task automatic expect_regs_unchanged();
    expect_reg(REG_SRC_ADDR, src_reg, "src_addr");
    expect_reg(REG_DST_ADDR, dst_reg, "dst_addr");
    expect_reg(REG_NUM_BYTES, bytes_reg, "num_bytes");
    expect_reg(REG_DONE_ID, {48'h0, done_id}, "done_id");
  endtask

  task automatic run_test(input test_row_t row);
    logic [DMA_DATA_W-1:0] rdata;
    logic                  err;
    case (row.kind)
      T_COPY: begin
        program_regs(row);
        launch_transfer(row);
        wait_done(row.exp_id);
        compare_memory();
      end
      // Second launch follows in the next row
      T_PAIR: begin
        program_regs(row);
        launch_transfer(row);
      end
      // A rejected launch leaves nothing queued or running
      T_ZERO: begin
        program_regs(row);
        launch_transfer(row);
        expect_reg(REG_STATUS, 64'h0, "status.busy");
        expect_reg(REG_DONE_ID, {48'h0, done_id}, "done_id");
        compare_memory();
      end
      T_BADRD: begin
        read_reg(row.reg_off, rdata, err);
        if (err !== row.exp_err) begin
          report_mismatch("reg_rsp.error", err, row.exp_err);
        end
        expect_regs_unchanged();
      end
      T_BADWR: begin
        write_reg(row.reg_off, '1, err);
        if (err !== row.exp_err) begin
          report_mismatch("reg_rsp.error", err, row.exp_err);
        end
        expect_regs_unchanged();
      end
      T_BUSY: begin
        slow = 1'b1;
        program_regs(row);
        launch_transfer(row);
        expect_reg(REG_STATUS, 64'h1, "status.busy");
        wait_done(row.exp_id);
        expect_reg(REG_STATUS, 64'h0, "status.busy");
        slow = 1'b0;
        compare_memory();
      end
      default: report_failure("unknown test kind in table");
    endcase
  endtask

  function automatic test_row_t make_row(input test_kind_e kind,
                                         input logic [DMA_REG_ADDR_W-1:0] reg_off,
                                         input logic [31:0] src, input logic [31:0] dst,
                                         input logic [63:0] nbytes,
                                         input logic [15:0] exp_id, input logic exp_err);
    test_row_t row;
    row.kind    = kind;
    row.reg_off = reg_off;
    row.src     = src;
    row.dst     = dst;
    row.nbytes  = nbytes;
    row.exp_id  = exp_id;
    row.exp_err = exp_err;
    return row;
  endfunction

  function automatic string kind_text(input test_kind_e kind);
    case (kind)
      T_COPY:  return "copy";
      T_PAIR:  return "first of pair";
      T_ZERO:  return "zero length";
      T_BADRD: return "bad read";
      T_BADWR: return "bad write";
      T_BUSY:  return "busy status";
      default: return "unknown";
    endcase
  endfunction

  task automatic fill_table();
    tests[0]  = make_row(T_COPY,  6'h00, 32'h0000, 32'h1000, 64'd64,  16'd1, 1'b0);
    tests[1]  = make_row(T_COPY,  6'h00, 32'h0100, 32'h1100, 64'd8,   16'd2, 1'b0);
    tests[2]  = make_row(T_PAIR,  6'h00, 32'h0200, 32'h1200, 64'd120, 16'd3, 1'b0);
    tests[3]  = make_row(T_COPY,  6'h00, 32'h0400, 32'h1400, 64'd40,  16'd4, 1'b0);
    tests[4]  = make_row(T_ZERO,  6'h00, 32'h0500, 32'h1500, 64'd0,   16'd0, 1'b0);
    tests[5]  = make_row(T_ZERO,  6'h00, 32'h0500, 32'h1500, 64'd7,   16'd0, 1'b0);
    tests[6]  = make_row(T_COPY,  6'h00, 32'h0600, 32'h1600, 64'd23,  16'd5, 1'b0);
    tests[7]  = make_row(T_BADRD, 6'h30, 32'h0,    32'h0,    64'd0,   16'd0, 1'b1);
    tests[8]  = make_row(T_BADWR, REG_STATUS,  32'h0, 32'h0, 64'd0,   16'd0, 1'b1);
    tests[9]  = make_row(T_BADWR, REG_NEXT_ID, 32'h0, 32'h0, 64'd0,   16'd0, 1'b1);
    tests[10] = make_row(T_BADWR, REG_DONE_ID, 32'h0, 32'h0, 64'd0,   16'd0, 1'b1);
    tests[11] = make_row(T_BUSY,  6'h00, 32'h0700, 32'h1700, 64'd256, 16'd6, 1'b0);
    tests[12] = make_row(T_COPY,  6'h00, 32'h0800, 32'h1800, 64'd512, 16'd7, 1'b0);
  endtask

  initial begin
    logic [DMA_DATA_W-1:0] word;
    int                    errs_before;
    void'($urandom(SEED));
    rst_n      = 1'b0;
    slow       = 1'b0;
    reg_req    = '0;
    src_reg    = '0;
    dst_reg    = '0;
    bytes_reg  = '0;
    done_id    = '0;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    fill_table();
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      word = {$urandom(), $urandom()};
      exp_mem[i] = word;
      dma_mem_model_inst.write_word(i, word);
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (reg_rsp.ready !== 1'b0) begin
      report_mismatch("reg_rsp.ready", reg_rsp.ready, 64'h0);
    end
    if (reg_rsp.error !== 1'b0) begin
      report_mismatch("reg_rsp.error", reg_rsp.error, 64'h0);
    end
    if (mem_req.req !== 1'b0) begin
      report_mismatch("mem_req.req", mem_req.req, 64'h0);
    end
    expect_reg(REG_DONE_ID, 64'h0, "done_id");
    expect_reg(REG_STATUS, 64'h0, "status.busy");
    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before = err_count;
      run_test(tests[t]);
      if (err_count == errs_before) begin
        pass_count++;
        $display("Test %0d (%s): ok", t, kind_text(tests[t].kind));
      end else begin
        fail_count++;
        $display("Test %0d (%s): %0d errors", t, kind_text(tests[t].kind),
                 err_count - errs_before);
      end
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, pass_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Limit scales with the bytes copied over the whole table
  initial begin
    int unsigned limit;
    @(posedge rst_n);
    limit = WD_MARGIN;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += 20 * int'(tests[t].nbytes);
    end
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, a transfer or register access hung", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : dma_tb

`default_nettype wire

//--- dv/dma_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module dma_mem_model import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     slow_i,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  localparam int unsigned MEM_WORDS = 1024;

  logic [DMA_DATA_W-1:0] mem [MEM_WORDS];
  // Pending read answers, oldest first
  logic [DMA_DATA_W-1:0] rd_data_q [$];
  int unsigned           rd_due_q [$];
  int unsigned           cycle;
  int unsigned           idx;
  int unsigned           lat;
  logic                  gnt;

  function automatic int unsigned word_index(input logic [DMA_ADDR_W-1:0] addr);
    return (addr >> 3) % MEM_WORDS;
  endfunction

  task automatic write_word(input int unsigned i, input logic [DMA_DATA_W-1:0] data);
    mem[i] = data;
  endtask

  function automatic logic [DMA_DATA_W-1:0] read_word(input int unsigned i);
    return mem[i];
  endfunction

  initial begin
    mem_rsp_o = '0;
    cycle     = 0;
  end

  // Request and grant are both stable from here to the next rising edge
  always @(negedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_rsp_o <= '0;
      rd_data_q.delete();
      rd_due_q.delete();
      cycle = 0;
    end else begin
      cycle++;
      if (slow_i) begin
        gnt = ($urandom() % 4) == 0;
        lat = 4 + ($urandom() % 7);
      end else begin
        gnt = ($urandom() % 4) != 0;
        lat = 1 + ($urandom() % 4);
      end
      if (gnt && mem_req_i.req) begin
        idx = word_index(mem_req_i.addr);
        if (mem_req_i.we) begin
          for (int b = 0; b < DMA_STRB_W; b++) begin
            if (mem_req_i.be[b]) begin
              mem[idx][8*b +: 8] = mem_req_i.wdata[8*b +: 8];
            end
          end
        end else begin
          rd_data_q.push_back(mem[idx]);
          rd_due_q.push_back(cycle + lat);
        end
      end
      mem_rsp_o.gnt <= gnt;
      // Answers leave in request order and the head blocks later ones
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
        mem_rsp_o.rvalid <= 1'b1;
        mem_rsp_o.rdata  <= rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
      end else begin
        mem_rsp_o.rvalid <= 1'b0;
      end
    end
  end

endmodule : dma_mem_model

`default_nettype wire

//--- design/dma_core_wrap.sv
`timescale 1ns/1ns
`default_nettype none

module dma_core_wrap import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  dma_req_t dma_req;
  logic     dma_valid;
  logic     dma_ready;
  logic     backend_idle;
  logic     trans_complete;

  // Register slave holding one queued job
  dma_reg_frontend dma_reg_frontend_inst (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .reg_req_i        ( reg_req_i      ),
    .reg_rsp_o        ( reg_rsp_o      ),
    .dma_req_o        ( dma_req        ),
    .dma_valid_o      ( dma_valid      ),
    .dma_ready_i      ( dma_ready      ),
    .backend_idle_i   ( backend_idle   ),
    .trans_complete_i ( trans_complete )
  );

  // Word copier on the memory port
  dma_backend dma_backend_inst (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .dma_req_i        ( dma_req        ),
    .dma_valid_i      ( dma_valid      ),
    .dma_ready_o      ( dma_ready      ),
    .mem_req_o        ( mem_req_o      ),
    .mem_rsp_i        ( mem_rsp_i      ),
    .idle_o           ( backend_idle   ),
    .trans_complete_o ( trans_complete )
  );

endmodule : dma_core_wrap

`default_nettype wire

//--- design/dma_reg_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module dma_reg_frontend import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output dma_req_t dma_req_o,
  output logic     dma_valid_o,
  input  logic     dma_ready_i,
  input  logic     backend_idle_i,
  input  logic     trans_complete_i
);

  logic [DMA_DATA_W-1:0] src_addr_q;
  logic [DMA_DATA_W-1:0] dst_addr_q;
  logic [DMA_DATA_W-1:0] num_bytes_q;
  logic [DMA_ID_W-1:0]   next_id_q;
  logic [DMA_ID_W-1:0]   done_id_q;
  logic [DMA_ADDR_W-1:0] num_words;

  logic                  rsp_ready_q;
  logic                  rsp_error_q;
  logic [DMA_DATA_W-1:0] rsp_rdata_q;
  logic                  rsp_error_d;
  logic [DMA_DATA_W-1:0] rsp_rdata_d;

  logic                  dma_valid_q;
  dma_req_t              dma_req_q;

  logic                  next_id_rd;
  logic                  launch_blocked;
  logic                  access;
  logic                  launch;
  logic                  busy;
  logic                  wr_src;
  logic                  wr_dst;
  logic                  wr_bytes;

  // Merge write data into a register under byte strobes
  function automatic logic [DMA_DATA_W-1:0] apply_strb(
    input logic [DMA_DATA_W-1:0] old_val,
    input logic [DMA_DATA_W-1:0] wdata,
    input logic [DMA_STRB_W-1:0] strb
  );
    logic [DMA_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < DMA_STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ID 0 means rejected, so counters skip it on wrap
  function automatic logic [DMA_ID_W-1:0] id_inc(input logic [DMA_ID_W-1:0] id);
    if (id == '1) begin
      return {{(DMA_ID_W-1){1'b0}}, 1'b1};
    end
    return id + 1'b1;
  endfunction

  // Byte count rounded down to whole words
  assign num_words = num_bytes_q[DMA_ADDR_W+2:3];

  assign busy           = dma_valid_q || !backend_idle_i;
  assign next_id_rd     = reg_req_i.valid && !reg_req_i.write && (reg_req_i.addr == REG_NEXT_ID);
  assign launch_blocked = dma_valid_q && !dma_ready_i;

  // Skip the response cycle itself, and hold off a launch while one is still queued
  assign access = reg_req_i.valid && !rsp_ready_q && !(next_id_rd && launch_blocked);
  assign launch = access && next_id_rd && (num_words != '0);

  always_comb begin
    rsp_rdata_d = '0;
    rsp_error_d = 1'b0;
    wr_src      = 1'b0;
    wr_dst      = 1'b0;
    wr_bytes    = 1'b0;
    case (reg_req_i.addr)
      REG_SRC_ADDR: begin
        rsp_rdata_d = src_addr_q;
        wr_src      = reg_req_i.write;
      end
      REG_DST_ADDR: begin
        rsp_rdata_d = dst_addr_q;
        wr_dst      = reg_req_i.write;
      end
      REG_NUM_BYTES: begin
        rsp_rdata_d = num_bytes_q;
        wr_bytes    = reg_req_i.write;
      end
      REG_STATUS: begin
        rsp_rdata_d = {{(DMA_DATA_W-1){1'b0}}, busy};
        rsp_error_d = reg_req_i.write;
      end
      REG_NEXT_ID: begin
        rsp_rdata_d = launch ? {{(DMA_DATA_W-DMA_ID_W){1'b0}}, next_id_q} : '0;
        rsp_error_d = reg_req_i.write;
      end
      REG_DONE_ID: begin
        rsp_rdata_d = {{(DMA_DATA_W-DMA_ID_W){1'b0}}, done_id_q};
        rsp_error_d = reg_req_i.write;
      end
      default: begin
        rsp_error_d = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_addr_q  <= '0;
      dst_addr_q  <= '0;
      num_bytes_q <= '0;
      next_id_q   <= {{(DMA_ID_W-1){1'b0}}, 1'b1};
      done_id_q   <= '0;
      rsp_ready_q <= 1'b0;
      rsp_error_q <= 1'b0;
      dma_valid_q <= 1'b0;
    end else begin
      rsp_ready_q <= access;
      if (access) begin
        rsp_error_q <= rsp_error_d;
      end
      if (access && wr_src) begin
        src_addr_q <= apply_strb(src_addr_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (access && wr_dst) begin
        dst_addr_q <= apply_strb(dst_addr_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (access && wr_bytes) begin
        num_bytes_q <= apply_strb(num_bytes_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (launch) begin
        next_id_q   <= id_inc(next_id_q);
        dma_valid_q <= 1'b1;
      end else if (dma_ready_i) begin
        dma_valid_q <= 1'b0;
      end
      if (trans_complete_i) begin
        done_id_q <= id_inc(done_id_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rsp_rdata_q <= rsp_rdata_d;
    end
    if (launch) begin
      dma_req_q.src_addr  <= src_addr_q[DMA_ADDR_W-1:0];
      dma_req_q.dst_addr  <= dst_addr_q[DMA_ADDR_W-1:0];
      dma_req_q.num_words <= num_words;
    end
  end

  assign reg_rsp_o.ready = rsp_ready_q;
  assign reg_rsp_o.rdata = rsp_rdata_q;
  assign reg_rsp_o.error = rsp_error_q;
  assign dma_req_o       = dma_req_q;
  assign dma_valid_o     = dma_valid_q;

endmodule : dma_reg_frontend

`default_nettype wire

//--- design/dma_backend.sv
`timescale 1ns/1ns
`default_nettype none

module dma_backend import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dma_req_t dma_req_i,
  input  logic     dma_valid_i,
  output logic     dma_ready_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     idle_o,
  output logic     trans_complete_o
);

  dma_state_e            state_q;
  dma_state_e            state_d;

  logic [DMA_ADDR_W-1:0] src_q;
  logic [DMA_ADDR_W-1:0] dst_q;
  logic [DMA_ADDR_W-1:0] rd_left_q;
  logic [DMA_ADDR_W-1:0] wr_left_q;
  // Buffer slots neither filled nor promised to an outstanding read
  logic [DMA_CNT_W-1:0]  credit_q;

  logic                  req_q;
  logic                  we_q;
  logic [DMA_ADDR_W-1:0] addr_q;
  logic [DMA_DATA_W-1:0] wdata_q;
  logic                  complete_q;

  logic                  accept;
  logic                  slot_free;
  logic                  issue_wr;
  logic                  issue_rd;
  logic [DMA_DATA_W-1:0] fifo_rdata;
  logic                  fifo_empty;

  assign accept    = dma_valid_i && (state_q == IDLE);
  // Request register may be reloaded once empty or granted
  assign slot_free = !req_q || mem_rsp_i.gnt;

  // Writes win the port whenever a word is buffered
  assign issue_wr = slot_free && (state_q == COPY) && !fifo_empty;
  assign issue_rd = slot_free && (state_q == COPY) && fifo_empty &&
                    (rd_left_q != '0) && (credit_q != '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = (dma_req_i.num_words == '0) ? DRAIN : COPY;
        end
      end
      COPY: begin
        if (issue_wr && (wr_left_q == 1)) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // Last write granted
        if (slot_free) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      src_q      <= '0;
      dst_q      <= '0;
      rd_left_q  <= '0;
      wr_left_q  <= '0;
      credit_q   <= DMA_CNT_W'(DMA_FIFO_DEPTH);
      req_q      <= 1'b0;
      complete_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      complete_q <= (state_q == DRAIN) && slot_free;
      if (slot_free) begin
        req_q <= issue_wr || issue_rd;
      end
      if (accept) begin
        src_q     <= dma_req_i.src_addr;
        dst_q     <= dma_req_i.dst_addr;
        rd_left_q <= dma_req_i.num_words;
        wr_left_q <= dma_req_i.num_words;
      end
      if (issue_rd) begin
        src_q     <= src_q + DMA_STRB_W;
        rd_left_q <= rd_left_q - 1'b1;
        credit_q  <= credit_q - 1'b1;
      end
      if (issue_wr) begin
        dst_q     <= dst_q + DMA_STRB_W;
        wr_left_q <= wr_left_q - 1'b1;
        credit_q  <= credit_q + 1'b1;
      end
    end
  end

  // Write data is taken from the buffer head as the word is popped
  always_ff @(posedge clk_i) begin
    if (issue_wr) begin
      we_q    <= 1'b1;
      addr_q  <= dst_q;
      wdata_q <= fifo_rdata;
    end else if (issue_rd) begin
      we_q    <= 1'b0;
      addr_q  <= src_q;
    end
  end

  dma_data_fifo dma_data_fifo_inst (
    .clk_i   ( clk_i            ),
    .rst_n_i ( rst_n_i          ),
    .push_i  ( mem_rsp_i.rvalid ),
    .data_i  ( mem_rsp_i.rdata  ),
    .pop_i   ( issue_wr         ),
    .data_o  ( fifo_rdata       ),
    .empty_o ( fifo_empty       ),
    .full_o  (                  )
  );

  assign mem_req_o.req   = req_q;
  assign mem_req_o.we    = we_q;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = wdata_q;
  assign mem_req_o.be    = '1;

  assign dma_ready_o      = (state_q == IDLE);
  assign idle_o           = (state_q == IDLE) && !complete_q;
  assign trans_complete_o = complete_q;

endmodule : dma_backend

`default_nettype wire

//--- design/dma_data_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module dma_data_fifo import dma_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  push_i,
  input  logic [DMA_DATA_W-1:0] data_i,
  input  logic                  pop_i,
  output logic [DMA_DATA_W-1:0] data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  logic [DMA_DATA_W-1:0] mem_q [DMA_FIFO_DEPTH];
  logic [DMA_PTR_W-1:0]  wr_ptr_q;
  logic [DMA_PTR_W-1:0]  rd_ptr_q;
  logic [DMA_CNT_W-1:0]  count_q;
  logic                  do_push;
  logic                  do_pop;

  function automatic logic [DMA_PTR_W-1:0] ptr_inc(input logic [DMA_PTR_W-1:0] ptr);
    if (ptr == DMA_PTR_W'(DMA_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == DMA_CNT_W'(DMA_FIFO_DEPTH));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head word is visible without a pop
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : dma_data_fifo

`default_nettype wire

//--- design/dma_pkg.sv
`default_nettype none

package dma_pkg;

  // Bus widths
  localparam int unsigned DMA_ADDR_W     = 32;
  localparam int unsigned DMA_DATA_W     = 64;
  localparam int unsigned DMA_STRB_W     = DMA_DATA_W / 8;
  localparam int unsigned DMA_REG_ADDR_W = 6;
  localparam int unsigned DMA_ID_W       = 16;

  // Word buffer sizing
  localparam int unsigned DMA_FIFO_DEPTH = 4;
  localparam int unsigned DMA_PTR_W      = $clog2(DMA_FIFO_DEPTH);
  localparam int unsigned DMA_CNT_W      = $clog2(DMA_FIFO_DEPTH + 1);

  // Register map in byte offsets
  localparam logic [DMA_REG_ADDR_W-1:0] REG_SRC_ADDR  = 6'h00;
  localparam logic [DMA_REG_ADDR_W-1:0] REG_DST_ADDR  = 6'h08;
  localparam logic [DMA_REG_ADDR_W-1:0] REG_NUM_BYTES = 6'h10;
  localparam logic [DMA_REG_ADDR_W-1:0] REG_STATUS    = 6'h18;
  localparam logic [DMA_REG_ADDR_W-1:0] REG_NEXT_ID   = 6'h20;
  localparam logic [DMA_REG_ADDR_W-1:0] REG_DONE_ID   = 6'h28;

  typedef enum logic [1:0] {
    IDLE,
    COPY,
    DRAIN
  } dma_state_e;

  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic [DMA_REG_ADDR_W-1:0] addr;
    logic [DMA_DATA_W-1:0]     wdata;
    logic [DMA_STRB_W-1:0]     wstrb;
  } reg_req_t;

  typedef struct packed {
    logic                  ready;
    logic [DMA_DATA_W-1:0] rdata;
    logic                  error;
  } reg_rsp_t;

  // One copy job as handed to the backend
  typedef struct packed {
    logic [DMA_ADDR_W-1:0] src_addr;
    logic [DMA_ADDR_W-1:0] dst_addr;
    logic [DMA_ADDR_W-1:0] num_words;
  } dma_req_t;

  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [DMA_ADDR_W-1:0] addr;
    logic [DMA_DATA_W-1:0] wdata;
    logic [DMA_STRB_W-1:0] be;
  } mem_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [DMA_DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage : dma_pkg

`default_nettype wire
